/* Bender.yml */
package:
  name: rob

export_include_dirs:
  - include

sources:
  - files:
      - design/rob_pkg.sv
      - design/rob_head_if.sv
      - design/rob_ptr_ctrl.sv
      - design/rob_entry_table.sv
      - design/rob_retire.sv
      - design/rob.sv
  - target: test
    files:
      - dv/rob_tb.sv

/* design/rob.sv */
/*
 * Single-issue reorder buffer top level.
 * One dispatch and one retire per cycle, several writeback ports and
 * tail rollback on a mispredict. Only wires the pointer, table and
 * retire blocks together.
 */

`include "rob_cfg.svh"

module rob import rob_pkg::*; (
    input  logic                           clock,
    input  logic                           reset,
    // dispatch
    input  logic                           disp_valid_i,
    input  logic                           disp_rd_wen_i,
    input  arch_reg_t                      disp_rd_arch_i,
    input  phys_reg_t                      disp_new_prf_i,
    input  phys_reg_t                      disp_old_prf_i,
    output logic                           disp_ready_o,
    output rob_idx_t                       disp_rob_idx_o,
    output rob_cnt_t                       free_space_o,
    // writeback
    input  logic [`ROB_WB_PORTS-1:0]       wb_valid_i,
    input  rob_idx_t [`ROB_WB_PORTS-1:0]   wb_rob_idx_i,
    input  rob_value_t [`ROB_WB_PORTS-1:0] wb_value_i,
    // mispredict
    input  logic                           mispredict_i,
    input  rob_idx_t                       mispredict_rob_idx_i,
    // commit
    output logic                           commit_valid_o,
    output logic                           commit_rd_wen_o,
    output arch_reg_t                      commit_rd_arch_o,
    output phys_reg_t                      commit_new_prf_o,
    output phys_reg_t                      commit_old_prf_o,
    output rob_value_t                     commit_value_o
);

    logic alloc_en;
    logic rob_empty;
    logic retire_en;

    rob_head_if head_if ();

    // tail index doubles as the returned dispatch index
    rob_ptr_ctrl u_ptr_ctrl (
        .clock                (clock),
        .reset                (reset),
        .disp_valid_i         (disp_valid_i),
        .mispredict_i         (mispredict_i),
        .mispredict_rob_idx_i (mispredict_rob_idx_i),
        .retire_en_i          (retire_en),
        .disp_ready_o         (disp_ready_o),
        .alloc_en_o           (alloc_en),
        .alloc_idx_o          (disp_rob_idx_o),
        .free_space_o         (free_space_o),
        .rob_empty_o          (rob_empty),
        .head_if              (head_if.ptr)
    );

    rob_entry_table u_entry_table (
        .clock          (clock),
        .reset          (reset),
        .alloc_en_i     (alloc_en),
        .alloc_idx_i    (disp_rob_idx_o),
        .disp_rd_wen_i  (disp_rd_wen_i),
        .disp_rd_arch_i (disp_rd_arch_i),
        .disp_new_prf_i (disp_new_prf_i),
        .disp_old_prf_i (disp_old_prf_i),
        .wb_valid_i     (wb_valid_i),
        .wb_rob_idx_i   (wb_rob_idx_i),
        .wb_value_i     (wb_value_i),
        .head_if        (head_if.tbl)
    );

    rob_retire u_retire (
        .clock            (clock),
        .reset            (reset),
        .rob_empty_i      (rob_empty),
        .mispredict_i     (mispredict_i),
        .retire_en_o      (retire_en),
        .commit_valid_o   (commit_valid_o),
        .commit_rd_wen_o  (commit_rd_wen_o),
        .commit_rd_arch_o (commit_rd_arch_o),
        .commit_new_prf_o (commit_new_prf_o),
        .commit_old_prf_o (commit_old_prf_o),
        .commit_value_o   (commit_value_o),
        .head_if          (head_if.retire)
    );

endmodule

/* design/rob_entry_table.sv */
/*
 * Entry storage for the reorder buffer.
 * Dispatch writes the rename mapping, writeback ports mark entries done
 * and store their results, and the head entry is read out for retire.
 */

`include "rob_cfg.svh"

module rob_entry_table import rob_pkg::*; (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                alloc_en_i,
    input  rob_idx_t                            alloc_idx_i,
    input  logic                                disp_rd_wen_i,
    input  arch_reg_t                           disp_rd_arch_i,
    input  phys_reg_t                           disp_new_prf_i,
    input  phys_reg_t                           disp_old_prf_i,
    input  logic [`ROB_WB_PORTS-1:0]            wb_valid_i,
    input  rob_idx_t [`ROB_WB_PORTS-1:0]        wb_rob_idx_i,
    input  rob_value_t [`ROB_WB_PORTS-1:0]      wb_value_i,
    rob_head_if.tbl                             head_if
);

    // per entry completion flag
    logic [`ROB_DEPTH-1:0] ready_q;

    // per entry payload
    logic       rd_wen_q  [`ROB_DEPTH];
    arch_reg_t  rd_arch_q [`ROB_DEPTH];
    phys_reg_t  new_prf_q [`ROB_DEPTH];
    phys_reg_t  old_prf_q [`ROB_DEPTH];
    rob_value_t value_q   [`ROB_DEPTH];

    // ==================================================
    // completion tracking
    // ==================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            ready_q <= '0;
        end else begin
            // a fresh entry starts incomplete, also covers squashed slots
            if (alloc_en_i) begin
                ready_q[alloc_idx_i] <= 1'b0;
            end
            for (int p = 0; p < `ROB_WB_PORTS; p++) begin
                if (wb_valid_i[p]) begin
                    ready_q[wb_rob_idx_i[p]] <= 1'b1;
                end
            end
        end
    end

    // mapping written at dispatch, result at writeback
    always_ff @(posedge clock) begin
        if (alloc_en_i) begin
            rd_wen_q[alloc_idx_i]  <= disp_rd_wen_i;
            rd_arch_q[alloc_idx_i] <= disp_rd_arch_i;
            new_prf_q[alloc_idx_i] <= disp_new_prf_i;
            old_prf_q[alloc_idx_i] <= disp_old_prf_i;
        end
        for (int p = 0; p < `ROB_WB_PORTS; p++) begin
            if (wb_valid_i[p]) begin
                value_q[wb_rob_idx_i[p]] <= wb_value_i[p];
            end
        end
    end

    // head read, combinational
    assign head_if.head_ready   = ready_q[head_if.head_idx];
    assign head_if.head_rd_wen  = rd_wen_q[head_if.head_idx];
    assign head_if.head_rd_arch = rd_arch_q[head_if.head_idx];
    assign head_if.head_new_prf = new_prf_q[head_if.head_idx];
    assign head_if.head_old_prf = old_prf_q[head_if.head_idx];
    assign head_if.head_value   = value_q[head_if.head_idx];

endmodule

/* design/rob_head_if.sv */
/*
 * Head of the reorder buffer as seen by retire.
 * Pointer logic drives the index, the entry table returns that entry's
 * fields, and retire consumes them.
 */

interface rob_head_if import rob_pkg::*; ();

    // oldest entry index
    rob_idx_t   head_idx;

    // fields of the entry at head_idx
    logic       head_ready;
    logic       head_rd_wen;
    arch_reg_t  head_rd_arch;
    phys_reg_t  head_new_prf;
    phys_reg_t  head_old_prf;
    rob_value_t head_value;

    modport ptr (output head_idx);

    // entry storage side
    modport tbl (input head_idx, output head_ready, head_rd_wen, head_rd_arch,
                 head_new_prf, head_old_prf, head_value);

    modport retire (input head_ready, head_rd_wen, head_rd_arch, head_new_prf,
                    head_old_prf, head_value);

endinterface

/* design/rob_pkg.sv */
/*
 * Shared types for the reorder buffer.
 * Widths follow the macros in the config header.
 * Modules take this package with a wildcard import in their header.
 */

`include "rob_cfg.svh"

package rob_pkg;

    // entry index into the buffer
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // occupancy and free space, one bit wider so a full buffer fits
    typedef logic [$clog2(`ROB_DEPTH):0] rob_cnt_t;

    // architectural destination
    typedef logic [$clog2(`ROB_ARCH_REGS)-1:0] arch_reg_t;

    // physical register tags, new mapping and the one it replaces
    typedef logic [$clog2(`ROB_PHYS_REGS)-1:0] phys_reg_t;

    // writeback result
    typedef logic [`ROB_XLEN-1:0] rob_value_t;

endpackage

/* design/rob_ptr_ctrl.sv */
/*
 * Head, tail and occupancy tracking for the reorder buffer.
 * Accepts one dispatch per cycle, advances the head on retire and
 * rolls the tail back to just after a mispredicted entry.
 */

`include "rob_cfg.svh"

module rob_ptr_ctrl import rob_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     disp_valid_i,
    input  logic     mispredict_i,
    input  rob_idx_t mispredict_rob_idx_i,
    input  logic     retire_en_i,
    output logic     disp_ready_o,
    output logic     alloc_en_o,
    output rob_idx_t alloc_idx_o,
    output rob_cnt_t free_space_o,
    output logic     rob_empty_o,
    rob_head_if.ptr  head_if
);

    localparam rob_cnt_t DEPTH_CNT = rob_cnt_t'(`ROB_DEPTH);
    localparam rob_idx_t LAST_IDX  = rob_idx_t'(`ROB_DEPTH - 1);

    rob_idx_t head_q;
    rob_idx_t tail_q;
    rob_cnt_t count_q;

    // entries kept on a squash, head through the mispredicted one
    rob_cnt_t mis_cnt;
    rob_cnt_t head_cnt;
    rob_cnt_t keep_cnt;

    // wrap at the last entry
    function automatic rob_idx_t idx_inc(input rob_idx_t idx);
        return (idx == LAST_IDX) ? '0 : idx + 1'b1;
    endfunction

    // ==================================================
    // status and dispatch acceptance
    // ==================================================
    assign rob_empty_o  = (count_q == '0);
    // no new entries while the tail is being rolled back
    assign disp_ready_o = (count_q != DEPTH_CNT) && !mispredict_i;
    assign alloc_en_o   = disp_valid_i && disp_ready_o;
    assign alloc_idx_o  = tail_q;
    assign free_space_o = DEPTH_CNT - count_q;
    assign head_if.head_idx = head_q;

    // distance head to mispredicted entry, inclusive
    assign mis_cnt  = {1'b0, mispredict_rob_idx_i};
    assign head_cnt = {1'b0, head_q};

    always_comb begin
        if (mis_cnt >= head_cnt) begin
            keep_cnt = mis_cnt - head_cnt + 1'b1;
        end else begin
            // mispredicted entry sits past the wrap
            keep_cnt = mis_cnt + DEPTH_CNT - head_cnt + 1'b1;
        end
    end

    // ==================================================
    // pointer update
    // ==================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (mispredict_i) begin
            // retire is held off this cycle, head stays put
            tail_q  <= idx_inc(mispredict_rob_idx_i);
            count_q <= keep_cnt;
        end else begin
            if (alloc_en_o) begin
                tail_q <= idx_inc(tail_q);
            end
            if (retire_en_i) begin
                head_q <= idx_inc(head_q);
            end
            // dispatch and retire together leave count alone
            case ({alloc_en_o, retire_en_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* design/rob_retire.sv */
/*
 * In-order retire stage of the reorder buffer.
 * Commits the head entry once it is complete and registers its
 * mapping and value onto the commit outputs for one cycle.
 */

module rob_retire import rob_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       rob_empty_i,
    input  logic       mispredict_i,
    output logic       retire_en_o,
    output logic       commit_valid_o,
    output logic       commit_rd_wen_o,
    output arch_reg_t  commit_rd_arch_o,
    output phys_reg_t  commit_new_prf_o,
    output phys_reg_t  commit_old_prf_o,
    output rob_value_t commit_value_o,
    rob_head_if.retire head_if
);

    // oldest entry done, nothing being squashed this cycle
    assign retire_en_o = !rob_empty_i && head_if.head_ready && !mispredict_i;

    // ==================================================
    // commit outputs
    // ==================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid_o <= 1'b0;
        end else begin
            // single cycle pulse per retired entry
            commit_valid_o <= retire_en_o;
        end
    end

    // payload only loads on retire, qualified by commit_valid_o
    always_ff @(posedge clock) begin
        if (retire_en_o) begin
            commit_rd_wen_o  <= head_if.head_rd_wen;
            commit_rd_arch_o <= head_if.head_rd_arch;
            commit_new_prf_o <= head_if.head_new_prf;
            commit_old_prf_o <= head_if.head_old_prf;
            commit_value_o   <= head_if.head_value;
        end
    end

endmodule

/* dv/rob_tb.sv */
/*
 * Self-checking testbench for the reorder buffer.
 * Drives dispatch, out-of-order writeback and mispredicts against a
 * queue model of the in-flight entries. Compile with the file list.
 */

`include "rob_cfg.svh"

module rob_tb import rob_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES   = 4;
    localparam int FILL_CYCLES    = `ROB_DEPTH + 4;
    localparam int RAND_CYCLES    = 400;
    localparam int DRAIN_CYCLES   = 2 * `ROB_DEPTH + 8;
    localparam int TIMEOUT_CYCLES =
        4 * (RESET_CYCLES + FILL_CYCLES + RAND_CYCLES + DRAIN_CYCLES);

    // one in-flight entry of the model
    typedef struct {
        rob_idx_t   idx;
        logic       rd_wen;
        arch_reg_t  arch;
        phys_reg_t  new_prf;
        phys_reg_t  old_prf;
        logic       done;
        // edges seen before the writeback was driven
        int         wb_cycle;
        rob_value_t value;
    } entry_t;

    logic                           clock;
    logic                           reset;
    logic                           disp_valid;
    logic                           disp_rd_wen;
    arch_reg_t                      disp_rd_arch;
    phys_reg_t                      disp_new_prf;
    phys_reg_t                      disp_old_prf;
    logic [`ROB_WB_PORTS-1:0]       wb_valid;
    rob_idx_t [`ROB_WB_PORTS-1:0]   wb_idx;
    rob_value_t [`ROB_WB_PORTS-1:0] wb_value;
    logic                           mispredict;
    rob_idx_t                       mispredict_idx;
    logic                           disp_ready_o;
    rob_idx_t                       disp_rob_idx_o;
    rob_cnt_t                       free_space_o;
    logic                           commit_valid_o;
    logic                           commit_rd_wen_o;
    arch_reg_t                      commit_rd_arch_o;
    phys_reg_t                      commit_new_prf_o;
    phys_reg_t                      commit_old_prf_o;
    rob_value_t                     commit_value_o;

    // oldest first
    entry_t      model[$];
    // dispatch payload waiting for disp_ready_o
    entry_t      hold;
    logic        hold_valid;
    rob_idx_t    exp_tail;
    logic [31:0] lfsr_state;
    int          error_count;
    int          commit_count;
    int          cycle_count;

    always #20 clock = ~clock;

    rob UUT (
        .clock                (clock),
        .reset                (reset),
        .disp_valid_i         (disp_valid),
        .disp_rd_wen_i        (disp_rd_wen),
        .disp_rd_arch_i       (disp_rd_arch),
        .disp_new_prf_i       (disp_new_prf),
        .disp_old_prf_i       (disp_old_prf),
        .disp_ready_o         (disp_ready_o),
        .disp_rob_idx_o       (disp_rob_idx_o),
        .free_space_o         (free_space_o),
        .wb_valid_i           (wb_valid),
        .wb_rob_idx_i         (wb_idx),
        .wb_value_i           (wb_value),
        .mispredict_i         (mispredict),
        .mispredict_rob_idx_i (mispredict_idx),
        .commit_valid_o       (commit_valid_o),
        .commit_rd_wen_o      (commit_rd_wen_o),
        .commit_rd_arch_o     (commit_rd_arch_o),
        .commit_new_prf_o     (commit_new_prf_o),
        .commit_old_prf_o     (commit_old_prf_o),
        .commit_value_o       (commit_value_o)
    );

    // ==================================================
    // random source and reference
    // ==================================================
    // taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_step()};
        end
        return r;
    endfunction

    // retire is in program order, so the oldest entry is next
    function automatic entry_t expected_commit();
        return model[0];
    endfunction

    // ==================================================
    // compare tasks
    // ==================================================
    task automatic check_commit(input logic got_wen, input arch_reg_t got_arch,
                                input phys_reg_t got_new, input phys_reg_t got_old,
                                input rob_value_t got_value, input entry_t exp);
        if (got_wen !== exp.rd_wen || got_arch !== exp.arch || got_new !== exp.new_prf ||
            got_old !== exp.old_prf || got_value !== exp.value) begin
            $display("FAILED %0t: commit %0d got %b/%0d/%0d/%0d/%h, expected %b/%0d/%0d/%0d/%h",
                     $time, exp.idx, got_wen, got_arch, got_new, got_old, got_value,
                     exp.rd_wen, exp.arch, exp.new_prf, exp.old_prf, exp.value);
            error_count++;
        end
    endtask

    task automatic check_idx(input rob_idx_t got, input rob_idx_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_cnt(input rob_cnt_t got, input rob_cnt_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    // ==================================================
    // one stimulus cycle with chances out of 4 (mispredict out of 16)
    // ==================================================
    task automatic drive_cycle(input int disp_chance, input int wb_chance,
                               input int mis_chance);
        int       pending[$];
        int       pick;
        int       keep;
        logic     mis;
        logic     exp_ready;
        rob_idx_t mis_idx;
        mis_idx = '0;
        @(negedge clock);
        // occupancy after the last edge
        check_cnt(free_space_o, rob_cnt_t'(`ROB_DEPTH - model.size()), "free_space_o");
        mis = (model.size() != 0) && (rand_bits(4) < mis_chance);
        exp_ready = (model.size() < `ROB_DEPTH) && !mis;
        mispredict = mis;
        mispredict_idx = '0;
        if (mis) begin
            // keep head through the mispredicted entry
            keep = rand_bits(8) % model.size();
            mis_idx = model[keep].idx;
            mispredict_idx = mis_idx;
            while (model.size() > keep + 1) begin
                void'(model.pop_back());
            end
        end
        // only entries already allocated and still incomplete
        foreach (model[i]) begin
            if (!model[i].done) pending.push_back(i);
        end
        wb_valid = '0;
        for (int p = 0; p < `ROB_WB_PORTS; p++) begin
            wb_idx[p] = '0;
            wb_value[p] = '0;
            if (pending.size() != 0 && rand_bits(2) < wb_chance) begin
                pick = rand_bits(8) % pending.size();
                wb_valid[p] = 1'b1;
                wb_idx[p] = model[pending[pick]].idx;
                wb_value[p] = rand_bits(32);
                model[pending[pick]].done = 1'b1;
                model[pending[pick]].wb_cycle = cycle_count;
                model[pending[pick]].value = wb_value[p];
                pending.delete(pick);
            end
        end
        // new payload only once the previous one went through
        if (!hold_valid && rand_bits(2) < disp_chance) begin
            hold.rd_wen = lfsr_step();
            hold.arch = arch_reg_t'(rand_bits($bits(arch_reg_t)));
            hold.new_prf = phys_reg_t'(rand_bits($bits(phys_reg_t)));
            hold.old_prf = phys_reg_t'(rand_bits($bits(phys_reg_t)));
            hold_valid = 1'b1;
        end
        disp_valid = hold_valid;
        disp_rd_wen = hold.rd_wen;
        disp_rd_arch = hold.arch;
        disp_new_prf = hold.new_prf;
        disp_old_prf = hold.old_prf;
        #1;
        check_flag(disp_ready_o, exp_ready, "disp_ready_o");
        if (hold_valid && disp_ready_o) begin
            check_idx(disp_rob_idx_o, exp_tail, "disp_rob_idx_o");
            hold.idx = exp_tail;
            hold.done = 1'b0;
            model.push_back(hold);
            exp_tail = rob_idx_t'((exp_tail + 1) % `ROB_DEPTH);
            hold_valid = 1'b0;
        end
        if (mis) exp_tail = rob_idx_t'((mis_idx + 1) % `ROB_DEPTH);
    endtask

    // commit outputs settle after the edge and the model pops the oldest
    always @(posedge clock) begin
        entry_t exp;
        #5;
        if (!reset && commit_valid_o) begin
            if (model.size() == 0) begin
                $display("commit at %0t with no entry in flight", $time);
                error_count++;
            end else begin
                exp = expected_commit();
                // the writeback edge stores the result, retire comes one edge later
                if (!exp.done || cycle_count < exp.wb_cycle + 2) begin
                    $display("FAILED %0t: entry %0d committed before its writeback",
                             $time, exp.idx);
                    error_count++;
                end
                check_commit(commit_rd_wen_o, commit_rd_arch_o, commit_new_prf_o,
                             commit_old_prf_o, commit_value_o, exp);
                void'(model.pop_front());
                commit_count++;
            end
        end
    end

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("simulation timed out after %0d cycles", cycle_count);
        $display("** FAIL **");
        $finish;
    end

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        clock = 1'b0;
        reset = 1'b1;
        disp_valid = 1'b0;
        disp_rd_wen = 1'b0;
        disp_rd_arch = '0;
        disp_new_prf = '0;
        disp_old_prf = '0;
        wb_valid = '0;
        wb_idx = '0;
        wb_value = '0;
        mispredict = 1'b0;
        mispredict_idx = '0;
        hold = '{default: '0};
        hold_valid = 1'b0;
        exp_tail = '0;
        lfsr_state = 32'h7789;
        error_count = 0;
        commit_count = 0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        check_cnt(free_space_o, rob_cnt_t'(`ROB_DEPTH), "free_space_o after reset");
        check_flag(disp_ready_o, 1'b1, "disp_ready_o after reset");
        check_flag(commit_valid_o, 1'b0, "commit_valid_o after reset");
        // fill with no writeback so the extra cycles sit against a full buffer
        repeat (FILL_CYCLES) drive_cycle(4, 0, 0);
        check_flag(disp_ready_o, 1'b0, "disp_ready_o when full");
        if (commit_count != 0 || model.size() != `ROB_DEPTH) begin
            $display("buffer did not fill: %0d entries in flight, %0d commits",
                     model.size(), commit_count);
            error_count++;
        end
        // mixed traffic with squashes
        repeat (RAND_CYCLES) drive_cycle(3, 2, 1);
        // write back whatever is left and let it retire
        while (model.size() != 0 || hold_valid) drive_cycle(0, 4, 0);
        repeat (4) drive_cycle(0, 0, 0);
        $display("%0d commits checked, %0d errors", commit_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* include/rob_cfg.svh */
/*
 * Reorder buffer sizing macros.
 * Included by the package and by any module that sizes arrays or ports.
 */

`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// number of buffer entries
`define ROB_DEPTH 16

// register file sizes seen by rename
`define ROB_ARCH_REGS 32
`define ROB_PHYS_REGS 64

// result value width
`define ROB_XLEN 32

// writeback ports into the buffer
`define ROB_WB_PORTS 2

`endif

/* rob.f */
+incdir+include
design/rob_pkg.sv
design/rob_head_if.sv
design/rob_ptr_ctrl.sv
design/rob_entry_table.sv
design/rob_retire.sv
design/rob.sv
dv/rob_tb.sv
